// File: mulPkg.sv
/*
 * mulPkg
 * Shared widths, pipeline depth, row types and full-adder helpers
 * for the pipelined 32x32 counter-tree multiplier.
 */
package mulPkg;

  localparam int opWidth   = 32;
  localparam int prodWidth = 64;

  // one partial-product row per multiplier bit
  localparam int numRows   = opWidth;

  // wide stage splits rows into groups of 15 for counter154
  localparam int groupRows = 15;
  localparam int numGroups = numRows / groupRows;
  localparam int leftRows  = numRows - numGroups * groupRows;

  // 4 count rows per group plus the leftover rows
  localparam int wideRows  = numGroups * 4 + leftRows;

  // tree stage splits wide rows into groups of 5 for counter53
  localparam int treeGroupRows = 5;
  localparam int treeGroups    = wideRows / treeGroupRows;

  // ppGen, wide, tree, final add
  localparam int pipeDepth = 4;

  typedef logic [opWidth-1:0]   operand_t;
  typedef logic [prodWidth-1:0] product_t;

  // row aligned to product weight
  typedef logic [prodWidth-1:0] row_t;

  function automatic logic fullAddSum(input logic a, input logic b, input logic c);
    return a ^ b ^ c;
  endfunction

  // majority of three
  function automatic logic fullAddCarry(input logic a, input logic b, input logic c);
    return (a & b) | (b & c) | (c & a);
  endfunction

endpackage

// File: counter53.sv
/*
 * counter53
 * Five-input bit counter, returns the number of ones as a 3-bit value.
 */
`timescale 1ns/1ps

module counter53 (
  input  logic [4:0] x_i,
  output logic [2:0] count_o
);

  logic orA, andA, oneA;
  logic orB, andB, oneB;
  logic bit0Carry;

  // pair x0/x1 and x2/x3 with OR/AND, x4 stands alone
  assign orA  = x_i[0] | x_i[1];
  assign andA = x_i[0] & x_i[1];
  assign oneA = orA & ~andA;
  assign orB  = x_i[2] | x_i[3];
  assign andB = x_i[2] & x_i[3];
  assign oneB = orB & ~andB;

  // weight-1 bits: the single-one flags and x4
  assign count_o[0] = oneA ^ oneB ^ x_i[4];
  assign bit0Carry  = (oneA & oneB) | (oneB & x_i[4]) | (x_i[4] & oneA);

  // weight-2 bits: both-one flags plus carry from bit 0
  assign count_o[1] = andA ^ andB ^ bit0Carry;
  assign count_o[2] = (andA & andB) | (andB & bit0Carry) | (bit0Carry & andA);

endmodule

// File: counter154.sv
/*
 * counter154
 * Fifteen-input bit counter. Five full adders compress the inputs,
 * two counter53 blocks count the sum and carry bits, and a short add
 * merges both counts into a 4-bit result.
 */
`timescale 1ns/1ps

module counter154 (
  input  logic [14:0] z_i,
  output logic [3:0]  count_o
);

  logic [4:0] faSum;
  logic [4:0] faCarry;
  logic [2:0] sumCount;
  logic [2:0] carryCount;

  // full adder i takes inputs 3i, 3i+1, 3i+2
  always_comb begin
    for (int i = 0; i < 5; i++) begin
      faSum[i]   = mulPkg::fullAddSum(z_i[3*i], z_i[3*i+1], z_i[3*i+2]);
      faCarry[i] = mulPkg::fullAddCarry(z_i[3*i], z_i[3*i+1], z_i[3*i+2]);
    end
  end

  counter53 u_sumCount (
    .x_i     (faSum),
    .count_o (sumCount)
  );

  counter53 u_carryCount (
    .x_i     (faCarry),
    .count_o (carryCount)
  );

  // carries weigh twice the sums, max 5 + 10 = 15
  assign count_o = {1'b0, sumCount} + {carryCount, 1'b0};

endmodule

// File: ppGenStage.sv
/*
 * ppGenStage
 * Pipeline stage 1. Forms the 32 shifted partial-product rows of a*b
 * and registers them together with the valid bit.
 */
`timescale 1ns/1ps

module ppGenStage (
  input  logic             clk_i,
  input  logic             rstN_i,
  input  mulPkg::operand_t a_i,
  input  mulPkg::operand_t b_i,
  input  logic             validIn_i,
  output mulPkg::row_t     rows_o [mulPkg::numRows],
  output logic             valid_o
);

  mulPkg::row_t ppRows [mulPkg::numRows];

  // AND array, row k is a masked by b[k] and moved to weight 2^k
  always_comb begin
    for (int k = 0; k < mulPkg::numRows; k++) begin
      ppRows[k] = mulPkg::row_t'(a_i & {mulPkg::opWidth{b_i[k]}}) << k;
    end
  end

  // data loads every cycle
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < mulPkg::numRows; k++) begin
      rows_o[k] <= ppRows[k];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= validIn_i;
    end
  end

endmodule

// File: wideCompressStage.sv
/*
 * wideCompressStage
 * Pipeline stage 2. Reduces 32 rows to 10 using one counter154 per
 * column in each group of 15 rows; leftover rows pass straight through.
 */
`timescale 1ns/1ps

module wideCompressStage (
  input  logic         clk_i,
  input  logic         rstN_i,
  input  mulPkg::row_t rows_i [mulPkg::numRows],
  input  logic         valid_i,
  output mulPkg::row_t rows_o [mulPkg::wideRows],
  output logic         valid_o
);

  logic [3:0]   colCount [mulPkg::numGroups][mulPkg::prodWidth];
  mulPkg::row_t wideComb [mulPkg::wideRows];

  genvar g, c;
  generate
    for (g = 0; g < mulPkg::numGroups; g++) begin : gGroup
      for (c = 0; c < mulPkg::prodWidth; c++) begin : gCol
        logic [mulPkg::groupRows-1:0] colBits;

        // one column slice of the 15 rows in this group
        always_comb begin
          for (int j = 0; j < mulPkg::groupRows; j++) begin
            colBits[j] = rows_i[g * mulPkg::groupRows + j][c];
          end
        end

        counter154 u_counter (
          .z_i     (colBits),
          .count_o (colCount[g][c])
        );
      end
    end
  endgenerate

  // count bit w of column c lands in column c+w, top bits fall off mod 2^64
  always_comb begin
    for (int gi = 0; gi < mulPkg::numGroups; gi++) begin
      for (int w = 0; w < 4; w++) begin
        wideComb[gi*4 + w] = '0;
        for (int ci = 0; ci + w < mulPkg::prodWidth; ci++) begin
          wideComb[gi*4 + w][ci + w] = colCount[gi][ci][w];
        end
      end
    end
    // rows 30 and 31 skip the counters
    for (int k = 0; k < mulPkg::leftRows; k++) begin
      wideComb[mulPkg::numGroups*4 + k] = rows_i[mulPkg::numGroups * mulPkg::groupRows + k];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < mulPkg::wideRows; k++) begin
      rows_o[k] <= wideComb[k];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

endmodule

// File: treeCompressStage.sv
/*
 * treeCompressStage
 * Pipeline stage 3. Counter53 columns take 10 rows down to 6, then three
 * carry-save levels leave a sum row and a carry row.
 */
`timescale 1ns/1ps

module treeCompressStage (
  input  logic         clk_i,
  input  logic         rstN_i,
  input  mulPkg::row_t rows_i [mulPkg::wideRows],
  input  logic         valid_i,
  output mulPkg::row_t sumRow_o,
  output mulPkg::row_t carryRow_o,
  output logic         valid_o
);

  logic [2:0]   colCount [mulPkg::treeGroups][mulPkg::prodWidth];
  mulPkg::row_t cntRows [mulPkg::treeGroups * 3];
  mulPkg::row_t sumA, carryA, sumB, carryB;
  mulPkg::row_t sumC, carryC, sumD, carryD;

  genvar g, c;
  generate
    for (g = 0; g < mulPkg::treeGroups; g++) begin : gGroup
      for (c = 0; c < mulPkg::prodWidth; c++) begin : gCol
        logic [mulPkg::treeGroupRows-1:0] colBits;

        always_comb begin
          for (int j = 0; j < mulPkg::treeGroupRows; j++) begin
            colBits[j] = rows_i[g * mulPkg::treeGroupRows + j][c];
          end
        end

        counter53 u_counter (
          .x_i     (colBits),
          .count_o (colCount[g][c])
        );
      end
    end
  endgenerate

  // 6 rows weighted 1, 2 and 4 per group
  always_comb begin
    for (int gi = 0; gi < mulPkg::treeGroups; gi++) begin
      for (int w = 0; w < 3; w++) begin
        cntRows[gi*3 + w] = '0;
        for (int ci = 0; ci + w < mulPkg::prodWidth; ci++) begin
          cntRows[gi*3 + w][ci + w] = colCount[gi][ci][w];
        end
      end
    end
  end

  // carry-save levels, carries move up one column
  always_comb begin
    for (int ci = 0; ci < mulPkg::prodWidth; ci++) begin
      sumA[ci]   = mulPkg::fullAddSum(cntRows[0][ci], cntRows[1][ci], cntRows[2][ci]);
      carryA[ci] = mulPkg::fullAddCarry(cntRows[0][ci], cntRows[1][ci], cntRows[2][ci]);
      sumB[ci]   = mulPkg::fullAddSum(cntRows[3][ci], cntRows[4][ci], cntRows[5][ci]);
      carryB[ci] = mulPkg::fullAddCarry(cntRows[3][ci], cntRows[4][ci], cntRows[5][ci]);
    end
    carryA = carryA << 1;
    carryB = carryB << 1;

    // 4 -> 3, carryB waits one level
    for (int ci = 0; ci < mulPkg::prodWidth; ci++) begin
      sumC[ci]   = mulPkg::fullAddSum(sumA[ci], carryA[ci], sumB[ci]);
      carryC[ci] = mulPkg::fullAddCarry(sumA[ci], carryA[ci], sumB[ci]);
    end
    carryC = carryC << 1;

    // 3 -> 2
    for (int ci = 0; ci < mulPkg::prodWidth; ci++) begin
      sumD[ci]   = mulPkg::fullAddSum(sumC[ci], carryC[ci], carryB[ci]);
      carryD[ci] = mulPkg::fullAddCarry(sumC[ci], carryC[ci], carryB[ci]);
    end
    carryD = carryD << 1;
  end

  always_ff @(posedge clk_i) begin
    sumRow_o   <= sumD;
    carryRow_o <= carryD;
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

endmodule

// File: finalAddStage.sv
/*
 * finalAddStage
 * Pipeline stage 4. Carry-propagate add of the sum and carry rows,
 * registered as the 64-bit product.
 */
`timescale 1ns/1ps

module finalAddStage (
  input  logic             clk_i,
  input  logic             rstN_i,
  input  mulPkg::row_t     sumRow_i,
  input  mulPkg::row_t     carryRow_i,
  input  logic             valid_i,
  output mulPkg::product_t product_o,
  output logic             valid_o
);

  mulPkg::product_t addResult;

  // carry out of bit 63 is dropped, product is exact in 64 bits
  assign addResult = sumRow_i + carryRow_i;

  always_ff @(posedge clk_i) begin
    product_o <= addResult;
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

endmodule

// File: fastMul32.sv
/*
 * fastMul32
 * Unsigned 32x32 multiplier, four register stages, one pair per clock.
 * Partial products, counter154 and counter53 reduction, final add.
 */
`timescale 1ns/1ps

module fastMul32 (
  input  logic             clk_i,
  input  logic             rstN_i,
  input  mulPkg::operand_t a_i,
  input  mulPkg::operand_t b_i,
  input  logic             validIn_i,
  output mulPkg::product_t product_o,
  output logic             validOut_o
);

  mulPkg::row_t ppRows   [mulPkg::numRows];
  mulPkg::row_t wideRows [mulPkg::wideRows];
  mulPkg::row_t sumRow;
  mulPkg::row_t carryRow;
  logic         validPp;
  logic         validWide;
  logic         validTree;

  ppGenStage u_ppGen (
    .clk_i     (clk_i),
    .rstN_i    (rstN_i),
    .a_i       (a_i),
    .b_i       (b_i),
    .validIn_i (validIn_i),
    .rows_o    (ppRows),
    .valid_o   (validPp)
  );

  wideCompressStage u_wide (
    .clk_i   (clk_i),
    .rstN_i  (rstN_i),
    .rows_i  (ppRows),
    .valid_i (validPp),
    .rows_o  (wideRows),
    .valid_o (validWide)
  );

  treeCompressStage u_tree (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .rows_i     (wideRows),
    .valid_i    (validWide),
    .sumRow_o   (sumRow),
    .carryRow_o (carryRow),
    .valid_o    (validTree)
  );

  finalAddStage u_finalAdd (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .sumRow_i   (sumRow),
    .carryRow_i (carryRow),
    .valid_i    (validTree),
    .product_o  (product_o),
    .valid_o    (validOut_o)
  );

endmodule

// File: fastMul32_properties.sv
/*
 * fastMul32_properties
 * Concurrent checks on the multiplier top level: valid latency,
 * reset clearing and known product data.
 */
`timescale 1ns/1ps

module fastMul32_properties (
  input logic             clk_i,
  input logic             rstN_i,
  input logic             validIn_i,
  input logic             validOut_o,
  input mulPkg::product_t product_o
);

  // validOut follows validIn by the pipeline depth once the pipe is out of reset
  validLatency: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    $past(rstN_i, mulPkg::pipeDepth) |->
      validOut_o == $past(validIn_i, mulPkg::pipeDepth)
  ) else $error("validOut_o does not follow validIn_i by pipeDepth cycles");

  // reset clears the valid chain
  resetClearsValid: assert property (
    @(posedge clk_i) !rstN_i |=> !validOut_o
  ) else $error("validOut_o high in the cycle after reset");

  knownProduct: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    validOut_o |-> !$isunknown(product_o)
  ) else $error("product_o holds X or Z while validOut_o is high");

endmodule

bind fastMul32 fastMul32_properties u_props (
  .clk_i      (clk_i),
  .rstN_i     (rstN_i),
  .validIn_i  (validIn_i),
  .validOut_o (validOut_o),
  .product_o  (product_o)
);

// File: tb_fastMul32.sv
/*
 * tb_fastMul32
 * Table-driven testbench for the pipelined 32x32 multiplier. Checks
 * products, fixed latency, result order with bubbles, and reset.
 */
`timescale 1ns/1ps

module tb_fastMul32;

  localparam int numCorner   = 14;
  localparam int numRandom   = 40;
  localparam int numEntries  = numCorner + numRandom;
  localparam int resetCycles = 3;
  localparam int driveDelay  = 2;

  logic             clk_i = 1'b0;
  logic             rstN_i;
  mulPkg::operand_t a_i;
  mulPkg::operand_t b_i;
  logic             validIn_i;
  mulPkg::product_t product_o;
  logic             validOut_o;

  // stimulus table with a gap flag that puts one idle cycle before the entry
  mulPkg::operand_t tabA   [numEntries];
  mulPkg::operand_t tabB   [numEntries];
  logic             tabGap [numEntries];

  // pending results in apply order
  mulPkg::product_t expQ [$];
  int               idxQ [$];
  int               cycQ [$];

  integer seed;
  int     cycleCount = 0;
  int     cycleLimit = 0;
  int     errorCount = 0;
  int     passCount  = 0;
  int     failCount  = 0;
  int     gapCount   = 0;
  int     outCount   = 0;

  fastMul32 dut_i (
    .clk_i      (clk_i),
    .rstN_i     (rstN_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .validIn_i  (validIn_i),
    .product_o  (product_o),
    .validOut_o (validOut_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycleCount <= cycleCount + 1;
  end

  task automatic setEntry(input int idx, input mulPkg::operand_t a,
                          input mulPkg::operand_t b, input logic gap);
    tabA[idx]   = a;
    tabB[idx]   = b;
    tabGap[idx] = gap;
  endtask

  task automatic fillTable();
    setEntry(0,  32'h0000_0000, 32'hdead_beef, 1'b0);
    setEntry(1,  32'h1234_5678, 32'h0000_0000, 1'b0);
    setEntry(2,  32'h0000_0001, 32'hcafe_f00d, 1'b0);
    setEntry(3,  32'h89ab_cdef, 32'h0000_0001, 1'b0);
    setEntry(4,  32'hffff_ffff, 32'hffff_ffff, 1'b0);
    // entry 5 has idle cycles on both sides
    setEntry(5,  32'h8000_0000, 32'h8000_0000, 1'b1);
    setEntry(6,  32'h8000_0000, 32'h0000_0001, 1'b1);
    setEntry(7,  32'h0000_0001, 32'h8000_0000, 1'b0);
    setEntry(8,  32'haaaa_aaaa, 32'h5555_5555, 1'b0);
    setEntry(9,  32'h5555_5555, 32'h5555_5555, 1'b0);
    setEntry(10, 32'haaaa_aaaa, 32'haaaa_aaaa, 1'b0);
    setEntry(11, 32'hffff_ffff, 32'h0000_0001, 1'b0);
    setEntry(12, 32'h0001_0000, 32'h0001_0000, 1'b0);
    setEntry(13, 32'hffff_ffff, 32'h8000_0000, 1'b0);
    for (int i = numCorner; i < numEntries; i++) begin
      tabA[i]   = $random(seed);
      tabB[i]   = $random(seed);
      tabGap[i] = ($random(seed) & 7) == 0;
    end
    gapCount = 0;
    for (int i = 0; i < numEntries; i++) begin
      if (tabGap[i]) begin
        gapCount++;
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%016h expected 0x%016h", name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkResult();
    int               idx;
    int               startCycle;
    int               errBefore;
    mulPkg::product_t expProd;
    idx        = idxQ.pop_front();
    startCycle = cycQ.pop_front();
    expProd    = expQ.pop_front();
    errBefore  = errorCount;
    checkValue("product_o", product_o, expProd);
    checkValue("validOut_o latency", cycleCount - startCycle, mulPkg::pipeDepth);
    if (errorCount == errBefore) begin
      passCount++;
      $display("test %0d ok: 0x%08h * 0x%08h = 0x%016h", idx, tabA[idx], tabB[idx], product_o);
    end else begin
      failCount++;
      $display("test %0d bad: 0x%08h * 0x%08h", idx, tabA[idx], tabB[idx]);
    end
  endtask

  task automatic applyEntry(input int idx);
    if (tabGap[idx]) begin
      @(posedge clk_i);
      #driveDelay;
      // junk operands in the bubble
      a_i       = $random(seed);
      b_i       = $random(seed);
      validIn_i = 1'b0;
    end
    @(posedge clk_i);
    #driveDelay;
    a_i       = tabA[idx];
    b_i       = tabB[idx];
    validIn_i = 1'b1;
    expQ.push_back(mulPkg::product_t'(tabA[idx]) * mulPkg::product_t'(tabB[idx]));
    idxQ.push_back(idx);
    // the cycle this pair is applied in
    cycQ.push_back(cycleCount);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (validOut_o === 1'b1) begin
      outCount++;
      if (cycQ.size() == 0) begin
        $display("validOut_o went high with no pair pending at cycle %0d", cycleCount);
        errorCount++;
      end else begin
        checkResult();
      end
    end else if (validOut_o !== 1'b0) begin
      $display("validOut_o is unknown at cycle %0d", cycleCount);
      errorCount++;
    end else if (cycQ.size() != 0 && cycleCount - cycQ[0] >= mulPkg::pipeDepth) begin
      $display("test %0d bad: no result after %0d cycles", idxQ[0], mulPkg::pipeDepth);
      void'(expQ.pop_front());
      void'(idxQ.pop_front());
      void'(cycQ.pop_front());
      failCount++;
      errorCount++;
    end
  end

  initial begin
    @(posedge clk_i);
    while (cycleCount < cycleLimit) begin
      @(posedge clk_i);
    end
    $display("run timed out after %0d cycles", cycleCount);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rstN_i    = 1'b0;
    validIn_i = 1'b0;
    a_i       = '0;
    b_i       = '0;
    seed      = 32'hcf69_cc3f;
    fillTable();
    cycleLimit = numEntries + gapCount + resetCycles + mulPkg::pipeDepth + 20;

    repeat (resetCycles) @(posedge clk_i);
    #driveDelay;
    rstN_i = 1'b1;

    for (int i = 0; i < numEntries; i++) begin
      applyEntry(i);
    end
    @(posedge clk_i);
    #driveDelay;
    validIn_i = 1'b0;

    // drain and then watch for extra results
    while (cycQ.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (mulPkg::pipeDepth + 1) @(posedge clk_i);

    checkValue("result count", outCount, numEntries);
    $display("summary: %0d tests ok, %0d tests bad, %0d errors",
             passCount, failCount, errorCount);
    if (errorCount == 0 && failCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: flist.f
mulPkg.sv
counter53.sv
counter154.sv
ppGenStage.sv
wideCompressStage.sv
treeCompressStage.sv
finalAddStage.sv
fastMul32.sv
fastMul32_properties.sv
tb_fastMul32.sv
